// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = shift_unit_tb
FILELIST = list.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

// ==== hdl/issue_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_buffer import shift_pkg::*; #(
	parameter type entry_t = shift_info_t
) (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        alloc_en,
	input  logic [ISSUE_IW-1:0]         alloc_index,
	input  entry_t                      alloc_info,
	input  logic                        pop,
	input  logic [ISSUE_IW-1:0]         pop_index,
	output logic [ISSUE_DP-1:0]         malloc,
	output entry_t [ISSUE_DP-1:0]       entries
);

	logic   [ISSUE_DP-1:0] malloc_q;
	entry_t [ISSUE_DP-1:0] entries_q;

	// ========================================================================
	// allocated bits
	// ========================================================================
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			malloc_q <= '0;
		end else begin
			// pop and alloc never hit the same slot in one cycle
			if (pop) begin
				malloc_q[pop_index] <= 1'b0;
			end
			if (alloc_en) begin
				malloc_q[alloc_index] <= 1'b1;
			end
		end
	end

	// payload storage
	always_ff @(posedge CLK) begin
		if (alloc_en) begin
			entries_q[alloc_index] <= alloc_info;
		end
	end

	assign malloc  = malloc_q;
	assign entries = entries_q;

	a_pop_allocated: assert property (
		@(posedge CLK) disable iff (!rst_n)
		pop |-> malloc_q[pop_index]
	) else $error("issue popped an empty buffer entry");

	a_alloc_free: assert property (
		@(posedge CLK) disable iff (!rst_n)
		alloc_en |-> !malloc_q[alloc_index]
	) else $error("dispatch allocated into an occupied buffer entry");

endmodule

`default_nettype wire

// ==== hdl/regfile_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile_scoreboard import shift_pkg::*; (
	input  logic                            CLK,
	input  logic                            rst_n,
	input  logic [ISSUE_DP-1:0][REG_AW-1:0] rs1_addr,
	input  logic [ISSUE_DP-1:0][REG_AW-1:0] rs2_addr,
	output logic [ISSUE_DP-1:0][XLEN-1:0]   rs1_data,
	output logic [ISSUE_DP-1:0][XLEN-1:0]   rs2_data,
	output logic [REG_NUM-1:0]              reg_ready,
	input  logic                            busy_en,
	input  logic [REG_AW-1:0]               busy_rd,
	input  logic                            wb_valid,
	input  logic [REG_AW-1:0]               wb_rd,
	input  logic [XLEN-1:0]                 wb_data,
	input  logic                            rf_load_en,
	input  logic [REG_AW-1:0]               rf_load_addr,
	input  logic [XLEN-1:0]                 rf_load_data
);

	logic [XLEN-1:0]    regs [REG_NUM];
	logic [REG_NUM-1:0] ready_q;

	// ========================================================================
	// integer register file
	// ========================================================================
	always_ff @(posedge CLK) begin
		if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
		if (rf_load_en && rf_load_addr != '0) begin
			regs[rf_load_addr] <= rf_load_data;
		end
	end

	for (genvar i = 0; i < ISSUE_DP; i++) begin : g_read
		assign rs1_data[i] = (rs1_addr[i] == '0) ? '0 : regs[rs1_addr[i]];
		assign rs2_data[i] = (rs2_addr[i] == '0) ? '0 : regs[rs2_addr[i]];
	end

	// ========================================================================
	// scoreboard
	// ========================================================================
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= '1;
		end else begin
			if (wb_valid) begin
				ready_q[wb_rd] <= 1'b1;
			end
			// the newer producer wins
			if (busy_en) begin
				ready_q[busy_rd] <= 1'b0;
			end
		end
	end

	// x0 never waits
	assign reg_ready = ready_q | REG_NUM'(1);

endmodule

`default_nettype wire

// ==== hdl/shift_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_dispatch import shift_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  logic [31:0]         instr,
	input  logic [ISSUE_DP-1:0] malloc,
	output logic                alloc_en,
	output logic [ISSUE_IW-1:0] alloc_index,
	output shift_info_t         alloc_info,
	output logic                busy_en,
	output logic [REG_AW-1:0]   busy_rd,
	output logic                buffer_full
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [6:0] funct7_rest;
	logic       is_imm64;
	logic       is_imm32;
	logic       is_reg64;
	logic       is_reg32;
	logic       arith;
	logic       dec_sll;
	logic       dec_srl;
	logic       dec_sra;
	logic       is_shift;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign arith  = funct7[F7_ARITH];

	assign is_imm64 = (opcode == OPC_OP_IMM);
	assign is_imm32 = (opcode == OPC_OP_IMM_32);
	assign is_reg64 = (opcode == OPC_OP);
	assign is_reg32 = (opcode == OPC_OP_32);

	// funct7 without the arith bit, and without shamt[5] for slli/srli/srai
	always_comb begin
		funct7_rest = funct7;
		funct7_rest[F7_ARITH] = 1'b0;
		if (is_imm64) begin
			funct7_rest[0] = 1'b0;
		end
	end

	assign dec_sll = (funct3 == F3_SLL) & ~arith;
	assign dec_srl = (funct3 == F3_SR) & ~arith;
	assign dec_sra = (funct3 == F3_SR) & arith;

	assign is_shift = (is_imm64 | is_imm32 | is_reg64 | is_reg32)
			& (dec_sll | dec_srl | dec_sra)
			& (funct7_rest == 7'b0);

	always_comb begin
		alloc_info           = '0;
		alloc_info.is_sll    = dec_sll;
		alloc_info.is_srl    = dec_srl;
		alloc_info.is_sra    = dec_sra;
		alloc_info.is32      = is_imm32 | is_reg32;
		alloc_info.use_imm   = is_imm64 | is_imm32;
		alloc_info.rd        = instr[11:7];
		alloc_info.rs1       = instr[19:15];
		// immediate forms leave rs2 at x0, which is always ready
		alloc_info.rs2       = (is_reg64 | is_reg32) ? instr[24:20] : '0;
		alloc_info.shamt_imm = {is_imm64 & instr[25], instr[24:20]};
	end

	// lowest free slot
	always_comb begin
		alloc_index = '0;
		for (int i = ISSUE_DP - 1; i >= 0; i--) begin
			if (!malloc[i]) begin
				alloc_index = ISSUE_IW'(i);
			end
		end
	end

	// the buffer and the scoreboard both take this on the next edge
	assign alloc_en    = instr_valid & is_shift;
	assign busy_en     = alloc_en;
	assign busy_rd     = alloc_info.rd;
	assign buffer_full = &malloc;

	// no shift may be offered while every slot is taken
	a_no_alloc_when_full: assert property (
		@(posedge CLK) disable iff (!rst_n)
		alloc_en |-> !(&malloc)
	) else $error("shift allocated while the issue buffer is full");

endmodule

`default_nettype wire

// ==== hdl/shift_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_execute import shift_pkg::*; (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              exe_valid,
	input  shift_exe_t        exe_param,
	output logic              wb_valid,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data
);

	logic [31:0]      word_in;
	logic [4:0]       amt_w;
	logic [31:0]      res_w;
	logic [XLEN-1:0]  res_d;
	logic [XLEN-1:0]  result;

	assign word_in = exe_param.op1[31:0];
	assign amt_w   = exe_param.op2[4:0];

	// word forms only see the low 32 bits
	always_comb begin
		if (exe_param.is_sll) begin
			res_w = word_in << amt_w;
		end else if (exe_param.is_srl) begin
			res_w = word_in >> amt_w;
		end else begin
			res_w = $signed(word_in) >>> amt_w;
		end
	end

	always_comb begin
		if (exe_param.is_sll) begin
			res_d = exe_param.op1 << exe_param.op2;
		end else if (exe_param.is_srl) begin
			res_d = exe_param.op1 >> exe_param.op2;
		end else begin
			res_d = $signed(exe_param.op1) >>> exe_param.op2;
		end
	end

	assign result = exe_param.is32 ? {{(XLEN - 32){res_w[31]}}, res_w} : res_d;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd   <= exe_param.rd;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/shift_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_issue import shift_pkg::*; (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  logic [ISSUE_DP-1:0]               malloc,
	input  shift_info_t [ISSUE_DP-1:0]        entries,
	input  logic [REG_NUM-1:0]                reg_ready,
	input  logic [ISSUE_DP-1:0][XLEN-1:0]     rs1_data,
	input  logic [ISSUE_DP-1:0][XLEN-1:0]     rs2_data,
	output logic [ISSUE_DP-1:0][REG_AW-1:0]   rs1_addr,
	output logic [ISSUE_DP-1:0][REG_AW-1:0]   rs2_addr,
	output logic                              pop,
	output logic [ISSUE_IW-1:0]               pop_index,
	output logic                              exe_valid,
	output shift_exe_t                        exe_param
);

	logic [ISSUE_DP-1:0] rs1_ready;
	logic [ISSUE_DP-1:0] rs2_ready;
	logic [ISSUE_DP-1:0] clear_raw;
	shift_exe_t          cand [ISSUE_DP];
	logic [ISSUE_IW-1:0] sel;
	logic                any_clear;

	// ========================================================================
	// wakeup, one candidate per entry
	// ========================================================================
	for (genvar i = 0; i < ISSUE_DP; i++) begin : g_entry
		assign rs1_addr[i]  = entries[i].rs1;
		assign rs2_addr[i]  = entries[i].rs2;
		assign rs1_ready[i] = reg_ready[entries[i].rs1];
		assign rs2_ready[i] = reg_ready[entries[i].rs2];

		// rs2 only matters for the register forms
		assign clear_raw[i] = malloc[i] & rs1_ready[i]
				& (entries[i].use_imm | rs2_ready[i]);

		always_comb begin
			cand[i].is_sll = entries[i].is_sll;
			cand[i].is_srl = entries[i].is_srl;
			cand[i].is_sra = entries[i].is_sra;
			cand[i].is32   = entries[i].is32;
			cand[i].rd     = entries[i].rd;
			cand[i].op1    = rs1_data[i];
			if (entries[i].use_imm) begin
				cand[i].op2 = entries[i].shamt_imm;
			end else if (entries[i].is32) begin
				cand[i].op2 = {1'b0, rs2_data[i][4:0]};
			end else begin
				cand[i].op2 = rs2_data[i][SHAMT_W-1:0];
			end
		end
	end

	// ========================================================================
	// select, lowest ready index wins
	// ========================================================================
	always_comb begin
		sel = '0;
		for (int i = ISSUE_DP - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				sel = ISSUE_IW'(i);
			end
		end
	end

	assign any_clear = |clear_raw;

	// execute is always ready, so any clear entry leaves this cycle
	assign pop       = any_clear;
	assign pop_index = sel;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= any_clear;
		end
	end

	always_ff @(posedge CLK) begin
		if (any_clear) begin
			exe_param <= cand[sel];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/shift_pkg.sv ====
`default_nettype none

package shift_pkg;

	// ========================================================================
	// widths and depths
	// ========================================================================
	localparam int XLEN     = 64;
	localparam int REG_AW   = 5;
	localparam int REG_NUM  = 1 << REG_AW;
	localparam int SHAMT_W  = 6;
	localparam int ISSUE_DP = 4;
	localparam int ISSUE_IW = $clog2(ISSUE_DP);

	// ========================================================================
	// rv64i shift group encodings
	// ========================================================================
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;

	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101;

	// bit position inside funct7, instr[30]
	localparam int F7_ARITH = 5;

	// one buffer entry, kind bits are one-hot
	typedef struct packed {
		logic               is_sll;
		logic               is_srl;
		logic               is_sra;
		logic               is32;
		logic               use_imm;
		logic [REG_AW-1:0]  rd;
		logic [REG_AW-1:0]  rs1;
		logic [REG_AW-1:0]  rs2;
		logic [SHAMT_W-1:0] shamt_imm;
	} shift_info_t;

	typedef struct packed {
		logic               is_sll;
		logic               is_srl;
		logic               is_sra;
		logic               is32;
		logic [REG_AW-1:0]  rd;
		logic [XLEN-1:0]    op1;
		logic [SHAMT_W-1:0] op2;
	} shift_exe_t;

endpackage

`default_nettype wire

// ==== hdl/shift_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_unit_top import shift_pkg::*; (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  logic [31:0]       instr,
	output logic              buffer_full,
	input  logic              rf_load_en,
	input  logic [REG_AW-1:0] rf_load_addr,
	input  logic [XLEN-1:0]   rf_load_data,
	output logic              wb_valid,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data
);

	logic                            alloc_en;
	logic [ISSUE_IW-1:0]             alloc_index;
	shift_info_t                     alloc_info;
	logic                            busy_en;
	logic [REG_AW-1:0]               busy_rd;
	logic [ISSUE_DP-1:0]             malloc;
	shift_info_t [ISSUE_DP-1:0]      entries;
	logic                            pop;
	logic [ISSUE_IW-1:0]             pop_index;
	logic [ISSUE_DP-1:0][REG_AW-1:0] rs1_addr;
	logic [ISSUE_DP-1:0][REG_AW-1:0] rs2_addr;
	logic [ISSUE_DP-1:0][XLEN-1:0]   rs1_data;
	logic [ISSUE_DP-1:0][XLEN-1:0]   rs2_data;
	logic [REG_NUM-1:0]              reg_ready;
	logic                            exe_valid;
	shift_exe_t                      exe_param;

	shift_dispatch u_dispatch (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.malloc      (malloc),
		.alloc_en    (alloc_en),
		.alloc_index (alloc_index),
		.alloc_info  (alloc_info),
		.busy_en     (busy_en),
		.busy_rd     (busy_rd),
		.buffer_full (buffer_full)
	);

	issue_buffer #(
		.entry_t (shift_info_t)
	) u_buffer (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.alloc_en    (alloc_en),
		.alloc_index (alloc_index),
		.alloc_info  (alloc_info),
		.pop         (pop),
		.pop_index   (pop_index),
		.malloc      (malloc),
		.entries     (entries)
	);

	shift_issue u_issue (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.malloc    (malloc),
		.entries   (entries),
		.reg_ready (reg_ready),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.pop       (pop),
		.pop_index (pop_index),
		.exe_valid (exe_valid),
		.exe_param (exe_param)
	);

	shift_execute u_execute (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_param (exe_param),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	regfile_scoreboard u_regfile (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.reg_ready    (reg_ready),
		.busy_en      (busy_en),
		.busy_rd      (busy_rd),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.rf_load_en   (rf_load_en),
		.rf_load_addr (rf_load_addr),
		.rf_load_data (rf_load_data)
	);

endmodule

`default_nettype wire

// ==== list.f ====
hdl/shift_pkg.sv
hdl/shift_dispatch.sv
hdl/issue_buffer.sv
hdl/shift_issue.sv
hdl/shift_execute.sv
hdl/regfile_scoreboard.sv
hdl/shift_unit_top.sv
verification/shift_unit_tb.sv

// ==== verification/shift_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_unit_tb import shift_pkg::*; ();

	localparam int MAX_ROWS = 40;
	localparam int MAX_LOADS = 10;
	localparam int DRAIN_CYCLES = 100;
	localparam int K_SLL = 0;
	localparam int K_SRL = 1;
	localparam int K_SRA = 2;

	logic              CLK = 1'b0;
	logic              rst_n;
	logic              instr_valid;
	logic [31:0]       instr;
	logic              buffer_full;
	logic              rf_load_en;
	logic [REG_AW-1:0] rf_load_addr;
	logic [XLEN-1:0]   rf_load_data;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;

	// instruction table
	string           row_name [MAX_ROWS];
	logic [31:0]     row_word [MAX_ROWS];
	logic [4:0]      row_rd [MAX_ROWS];
	logic [XLEN-1:0] row_exp [MAX_ROWS];
	int              row_after [MAX_ROWS];
	bit              row_last [MAX_ROWS];
	bit              row_done [MAX_ROWS];
	int              n_rows;

	// load table
	logic [4:0]      ld_addr [MAX_LOADS];
	logic [XLEN-1:0] ld_data [MAX_LOADS];
	int              n_loads;

	logic [XLEN-1:0] model_regs [32];
	bit              pend_valid [32];
	int              pend_row [32];
	int              pend_count;
	bit              seen_full;
	bit              table_ready;

	shift_unit_top uut (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.buffer_full  (buffer_full),
		.rf_load_en   (rf_load_en),
		.rf_load_addr (rf_load_addr),
		.rf_load_data (rf_load_data),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data)
	);

	always #10 CLK = ~CLK;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// ========================================================================
	// reference model and encoder
	// ========================================================================
	function automatic logic [XLEN-1:0] ref_shift(input int kind, input int is32,
			input logic [XLEN-1:0] a, input int amt);
		logic [31:0]     w;
		logic [XLEN-1:0] r;
		if (is32 != 0) begin
			w = a[31:0];
			for (int i = 0; i < amt; i++) begin
				if (kind == K_SLL) w = {w[30:0], 1'b0};
				else if (kind == K_SRL) w = {1'b0, w[31:1]};
				else w = {w[31], w[31:1]};
			end
			return {{32{w[31]}}, w};
		end
		r = a;
		for (int i = 0; i < amt; i++) begin
			if (kind == K_SLL) r = {r[XLEN-2:0], 1'b0};
			else if (kind == K_SRL) r = {1'b0, r[XLEN-1:1]};
			else r = {r[XLEN-1], r[XLEN-1:1]};
		end
		return r;
	endfunction

	function automatic logic [31:0] encode(input int kind, input int is32, input int use_imm,
			input int rd, input int rs1, input int src);
		logic [6:0] f7;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [5:0] s;
		s  = 6'(src);
		f7 = (kind == K_SRA) ? 7'b0100000 : 7'b0000000;
		f3 = (kind == K_SLL) ? F3_SLL : F3_SR;
		if (use_imm != 0) begin
			opc = (is32 != 0) ? OPC_OP_IMM_32 : OPC_OP_IMM;
			if (is32 == 0) f7[0] = s[5];
		end else begin
			opc = (is32 != 0) ? OPC_OP_32 : OPC_OP;
		end
		return {f7, s[4:0], 5'(rs1), f3, 5'(rd), opc};
	endfunction

	task automatic add_load(input int addr, input logic [XLEN-1:0] data);
		ld_addr[n_loads] = 5'(addr);
		ld_data[n_loads] = data;
		if (addr != 0) model_regs[addr] = data;
		n_loads++;
	endtask

	// src is the shift amount for immediate forms, else the rs2 index
	task automatic add_row(input string name, input int kind, input int is32,
			input int use_imm, input int rd, input int rs1, input int src, input int after);
		int amt;
		int n;
		n = n_rows;
		if (use_imm != 0) amt = src;
		else if (is32 != 0) amt = int'(model_regs[src][4:0]);
		else amt = int'(model_regs[src][5:0]);
		row_name[n]  = name;
		row_word[n]  = encode(kind, is32, use_imm, rd, rs1, src);
		row_rd[n]    = 5'(rd);
		row_exp[n]   = ref_shift(kind, is32, model_regs[rs1], amt);
		row_after[n] = after;
		row_last[n]  = 1'b0;
		row_done[n]  = 1'b0;
		if (rd != 0) model_regs[rd] = row_exp[n];
		n_rows++;
	endtask

	task automatic build_tables();
		int b;
		int p;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		add_load(1, 64'h8000_0000_F0F0_1234);
		add_load(2, 64'h0123_4567_89AB_CDEF);
		add_load(3, {$urandom, $urandom});
		add_load(4, {$urandom, 32'd31});
		add_load(5, {$urandom, 32'hFFFF_FFE0});
		add_load(6, 64'hFFFF_FFFF_FFFF_FFFF);
		add_load(7, {$urandom, $urandom});
		add_load(0, 64'hDEAD_BEEF_0000_0001);

		// every form at edge amounts
		add_row("slli_0", K_SLL, 0, 1, 8, 1, 0, -1);
		add_row("slli_63", K_SLL, 0, 1, 9, 1, 63, -1);
		add_row("slliw_31", K_SLL, 1, 1, 10, 1, 31, -1);
		add_row("sll_31", K_SLL, 0, 0, 11, 2, 4, -1);
		add_row("sllw_32", K_SLL, 1, 0, 12, 2, 5, -1);
		add_row("srli_32", K_SRL, 0, 1, 13, 1, 32, -1);
		add_row("srliw_31", K_SRL, 1, 1, 14, 1, 31, -1);
		add_row("srl_63", K_SRL, 0, 0, 15, 1, 6, -1);
		add_row("srlw_31", K_SRL, 1, 0, 16, 1, 4, -1);
		add_row("srai_63", K_SRA, 0, 1, 17, 1, 63, -1);
		add_row("sraiw_0", K_SRA, 1, 1, 18, 1, 0, -1);
		add_row("sra_32", K_SRA, 0, 0, 19, 1, 5, -1);
		add_row("sraw_31", K_SRA, 1, 0, 20, 3, 6, -1);
		add_row("srai_rand", K_SRA, 0, 1, 21, 7, int'($urandom_range(63, 0)), -1);
		add_row("sllw_rand", K_SLL, 1, 0, 22, 7, 7, -1);
		add_row("srlw_x2", K_SRL, 1, 0, 23, 1, 2, -1);
		row_last[n_rows-1] = 1'b1;

		// dependent chain
		add_row("chain_0", K_SRL, 0, 1, 8, 1, 4, -1);
		add_row("chain_1", K_SLL, 0, 1, 9, 8, 3, n_rows - 1);
		add_row("chain_2", K_SRA, 0, 1, 10, 9, 7, n_rows - 1);
		add_row("chain_3", K_SRA, 1, 0, 11, 10, 4, n_rows - 1);
		row_last[n_rows-1] = 1'b1;

		// independent row overtakes a blocked one while its shamt field names busy x11
		add_row("order_p0", K_SLL, 0, 1, 8, 2, 1, -1);
		add_row("order_p1", K_SRL, 0, 1, 9, 8, 1, n_rows - 1);
		add_row("order_p2", K_SLL, 0, 1, 10, 9, 2, n_rows - 1);
		b = n_rows;
		add_row("order_blocked", K_SRL, 0, 0, 11, 10, 4, -1);
		add_row("order_free", K_SLL, 0, 1, 12, 1, 11, -1);
		row_after[b] = n_rows - 1;
		row_last[n_rows-1] = 1'b1;

		// long chain keeps x13 busy while four readers fill the buffer
		add_row("fill_p0", K_SRL, 0, 1, 8, 2, 1, -1);
		for (int i = 1; i < 6; i++) begin
			add_row($sformatf("fill_p%0d", i), (i % 2 == 1) ? K_SLL : K_SRL, 0, 1,
					8 + i, 7 + i, 1, n_rows - 1);
		end
		p = n_rows - 1;
		add_row("fill_c1", K_SRA, 0, 1, 14, 13, 5, p);
		add_row("fill_c2", K_SLL, 1, 0, 15, 13, 5, p);
		add_row("fill_c3", K_SRL, 1, 1, 16, 13, int'($urandom_range(31, 0)), p);
		add_row("fill_c4", K_SLL, 0, 0, 17, 13, 7, p);
		row_last[n_rows-1] = 1'b1;

		// x0 stays zero after the write to it has landed
		add_row("write_x0", K_SLL, 0, 1, 0, 1, 5, -1);
		row_last[n_rows-1] = 1'b1;
		add_row("read_x0", K_SRL, 0, 1, 8, 0, 3, -1);
		add_row("amount_x0", K_SLL, 0, 0, 9, 1, 0, -1);
		row_last[n_rows-1] = 1'b1;
	endtask

	// ========================================================================
	// writeback monitor
	// ========================================================================
	always @(negedge CLK) begin : monitor
		int r;
		if (rst_n && buffer_full) seen_full = 1'b1;
		if (rst_n && wb_valid) begin
			assert (pend_valid[wb_rd])
			else abort_run($sformatf("writeback to x%0d with no pending instruction", wb_rd));
			r = pend_row[wb_rd];
			assert (wb_data == row_exp[r])
			else abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
					row_name[r], row_exp[r], wb_data));
			if (row_after[r] >= 0) begin
				assert (row_done[row_after[r]])
				else abort_run($sformatf("%s wrote back before %s", row_name[r],
						row_name[row_after[r]]));
			end
			row_done[r] = 1'b1;
			pend_valid[wb_rd] = 1'b0;
			pend_count--;
		end
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (n_rows * 40 + n_loads * 2 + 20) @(posedge CLK);
		abort_run("watchdog expired before all instructions wrote back");
	end

	// ========================================================================
	// stimulus
	// ========================================================================
	initial begin : stimulus
		int waited;
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		rf_load_en   = 1'b0;
		rf_load_addr = '0;
		rf_load_data = '0;
		pend_count   = 0;
		seen_full    = 1'b0;
		n_rows       = 0;
		n_loads      = 0;
		for (int i = 0; i < 32; i++) pend_valid[i] = 1'b0;
		void'($urandom(62083));
		build_tables();
		table_ready = 1'b1;

		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;

		for (int i = 0; i < n_loads; i++) begin
			@(posedge CLK);
			rf_load_en   <= 1'b1;
			rf_load_addr <= ld_addr[i];
			rf_load_data <= ld_data[i];
		end
		@(posedge CLK);
		rf_load_en <= 1'b0;

		// one row every other cycle, so buffer_full seen here holds for the strobe
		for (int i = 0; i < n_rows; i++) begin
			@(negedge CLK);
			while (buffer_full) @(negedge CLK);
			@(posedge CLK);
			instr_valid <= 1'b1;
			instr       <= row_word[i];
			pend_valid[row_rd[i]] = 1'b1;
			pend_row[row_rd[i]]   = i;
			pend_count++;
			@(posedge CLK);
			instr_valid <= 1'b0;
			if (row_last[i]) begin
				waited = 0;
				while (pend_count != 0 && waited < DRAIN_CYCLES) begin
					@(negedge CLK);
					waited++;
				end
				assert (pend_count == 0)
				else abort_run("instructions still pending after the drain wait");
			end
		end

		assert (seen_full)
		else abort_run("buffer_full never went high while the buffer was filled");
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
